// ==== hdl/nes_bus_pkg.sv ====
package nes_bus_pkg;

	// CPU side address, full 64 KB map
	typedef logic [15:0] addr_t;

	// One data byte on the bus
	typedef logic [7:0] byte_t;

	// One bus cycle request
	// we and re are single-cycle strobes, never high together
	typedef struct packed {
		addr_t addr;
		byte_t wdata;
		logic  we;
		logic  re;
	} bus_req_t;

	// PPU sprite attribute registers
	localparam addr_t ADDR_OAMADDR = 16'h2003;
	localparam addr_t ADDR_OAMDATA = 16'h2004;

	// Sprite DMA trigger, written with the source page
	localparam addr_t ADDR_OAMDMA = 16'h4014;

	// Work RAM mirrors repeat up to here
	localparam addr_t RAM_MIRROR_TOP = 16'h1FFF;

endpackage

// ==== hdl/oam_dma_pkg.sv ====
package oam_dma_pkg;

	// Sequencer states of the sprite DMA
	typedef enum logic [2:0] {
		IDLE,
		SAVE,
		CLEAR,
		READ,
		WRITE,
		RESTORE
	} dma_state_e;

	// Phase flags from the FSM to the address path
	// At most one flag is set per cycle
	typedef struct packed {
		logic save;
		logic clear;
		logic read;
		logic write;
		logic restore;
	} dma_ctrl_t;

endpackage

// ==== hdl/oam_dma_fsm.sv ====
`timescale 1ns/100ps

module oam_dma_fsm
	import oam_dma_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      dma_start,
	input  logic      last_byte,
	output logic      busy,
	output dma_ctrl_t ctrl,
	output logic      count_clear,
	output logic      count_advance
);

	dma_state_e state;
	dma_state_e state_next;

	// Next state
	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				// Page write to $4014 seen by the mux
				if (dma_start) begin
					state_next = SAVE;
				end
			end
			// Read of OAMADDR is issued here
			SAVE: state_next = CLEAR;
			// Old OAMADDR comes back, OAMADDR is zeroed
			CLEAR: state_next = READ;
			READ: state_next = WRITE;
			WRITE: begin
				// Byte $FF just moved, put OAMADDR back
				if (last_byte) begin
					state_next = RESTORE;
				end else begin
					state_next = READ;
				end
			end
			RESTORE: state_next = IDLE;
			default: state_next = IDLE;
		endcase
	end

	// State and busy registers
	// busy follows the next state so it lines up with the state itself
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= IDLE;
			busy  <= 1'b0;
		end else begin
			state <= state_next;
			busy  <= (state_next != IDLE);
		end
	end

	// One phase flag per active state
	always_comb begin
		ctrl         = '0;
		ctrl.save    = (state == SAVE);
		ctrl.clear   = (state == CLEAR);
		ctrl.read    = (state == READ);
		ctrl.write   = (state == WRITE);
		ctrl.restore = (state == RESTORE);
	end

	// Byte index starts over once the transfer begins
	assign count_clear = (state == CLEAR);

	// Index holds at $FF after the last byte
	assign count_advance = (state == WRITE) && !last_byte;

	// No phase may reach the address path while the bus is released
	a_idle_no_ctrl: assert property (@(posedge clk) disable iff (!rst)
		!busy |-> (ctrl == '0));

	// Bus is only handed back after OAMADDR is restored
	a_busy_fall: assert property (@(posedge clk) disable iff (!rst)
		$fell(busy) |-> ($past(state) == RESTORE));

endmodule

// ==== hdl/dma_byte_counter.sv ====
`timescale 1ns/100ps

module dma_byte_counter
	import nes_bus_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  clear,
	input  logic  advance,
	output byte_t count,
	output logic  last_byte
);

	// Low byte of the source address within the page
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			count <= '0;
		end else if (clear) begin
			count <= '0;
		end else if (advance) begin
			count <= count + 8'd1;
		end
	end

	// Final byte of the page
	assign last_byte = (count == 8'hFF);

	// FSM never starts over and steps in the same cycle
	a_clear_advance: assert property (@(posedge clk) disable iff (!rst)
		!(clear && advance));

endmodule

// ==== hdl/dma_address_path.sv ====
`timescale 1ns/100ps

module dma_address_path
	import nes_bus_pkg::*;
	import oam_dma_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      dma_start,
	input  byte_t     dma_page,
	input  dma_ctrl_t ctrl,
	input  byte_t     count,
	input  byte_t     bus_rdata,
	output bus_req_t  dma_req
);

	byte_t page_q;
	byte_t saved_q;

	// Source page from the $4014 write
	// Saved OAMADDR arrives one cycle after the SAVE read
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			page_q  <= '0;
			saved_q <= '0;
		end else begin
			if (dma_start) begin
				page_q <= dma_page;
			end
			if (ctrl.clear) begin
				saved_q <= bus_rdata;
			end
		end
	end

	// Request of the current phase
	always_comb begin
		dma_req = '0;
		if (ctrl.save) begin
			// Fetch the CPU's OAMADDR
			dma_req.addr = ADDR_OAMADDR;
			dma_req.re   = 1'b1;
		end else if (ctrl.clear) begin
			dma_req.addr  = ADDR_OAMADDR;
			dma_req.wdata = 8'h00;
			dma_req.we    = 1'b1;
		end else if (ctrl.read) begin
			// Source byte P:count
			dma_req.addr = {page_q, count};
			dma_req.re   = 1'b1;
		end else if (ctrl.write) begin
			// Byte read last cycle goes to OAMDATA, OAMADDR steps on its own
			dma_req.addr  = ADDR_OAMDATA;
			dma_req.wdata = bus_rdata;
			dma_req.we    = 1'b1;
		end else if (ctrl.restore) begin
			dma_req.addr  = ADDR_OAMADDR;
			dma_req.wdata = saved_q;
			dma_req.we    = 1'b1;
		end
	end

endmodule

// ==== hdl/bus_master_mux.sv ====
`timescale 1ns/100ps

module bus_master_mux
	import nes_bus_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     busy,
	input  bus_req_t cpu_req,
	input  bus_req_t dma_req,
	output bus_req_t ram_req,
	output bus_req_t oam_req,
	input  byte_t    ram_rdata,
	input  byte_t    oam_rdata,
	output byte_t    bus_rdata,
	output logic     dma_start,
	output byte_t    dma_page
);

	bus_req_t sel_req;
	logic     ram_hit;
	logic     oam_hit;
	logic     ram_rd_q;
	logic     oam_rd_q;

	// DMA owns the bus while busy, CPU requests are lost then
	assign sel_req = busy ? dma_req : cpu_req;

	// Address decode
	assign ram_hit = (sel_req.addr <= RAM_MIRROR_TOP);
	assign oam_hit = (sel_req.addr == ADDR_OAMADDR) || (sel_req.addr == ADDR_OAMDATA);

	// Strobes only reach the decoded target
	always_comb begin
		ram_req    = sel_req;
		ram_req.we = sel_req.we & ram_hit;
		ram_req.re = sel_req.re & ram_hit;
		oam_req    = sel_req;
		oam_req.we = sel_req.we & oam_hit;
		oam_req.re = sel_req.re & oam_hit;
	end

	// Remember who was read, data shows up one cycle later
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			ram_rd_q <= 1'b0;
			oam_rd_q <= 1'b0;
		end else begin
			ram_rd_q <= ram_req.re;
			oam_rd_q <= oam_req.re;
		end
	end

	// Unmapped reads give zero
	always_comb begin
		if (ram_rd_q) begin
			bus_rdata = ram_rdata;
		end else if (oam_rd_q) begin
			bus_rdata = oam_rdata;
		end else begin
			bus_rdata = '0;
		end
	end

	// $4014 write from the CPU, ignored during a transfer
	assign dma_start = !busy && cpu_req.we && (cpu_req.addr == ADDR_OAMDMA);
	assign dma_page  = cpu_req.wdata;

	// Engine stays quiet until it has been granted the bus
	a_dma_quiet: assert property (@(posedge clk) disable iff (!rst)
		!busy |-> !(dma_req.we || dma_req.re));

endmodule

// ==== hdl/cpu_work_ram.sv ====
`timescale 1ns/100ps

module cpu_work_ram
	import nes_bus_pkg::*;
#(
	parameter int RAM_ADDR_W = 11
)
(
	input  logic     clk,
	input  logic     rst,
	input  bus_req_t req,
	output byte_t    rdata
);

	// Physical RAM, 2 KB by default
	byte_t mem [2**RAM_ADDR_W];

	logic [RAM_ADDR_W-1:0] idx;

	// High address bits are dropped, so every mirror hits the same byte
	assign idx = req.addr[RAM_ADDR_W-1:0];

	// Array write
	always_ff @(posedge clk) begin
		if (req.we) begin
			mem[idx] <= req.wdata;
		end
	end

	// Read data one cycle after re
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			rdata <= '0;
		end else if (req.re) begin
			rdata <= mem[idx];
		end
	end

endmodule

// ==== hdl/ppu_oam_regs.sv ====
`timescale 1ns/100ps

module ppu_oam_regs
	import nes_bus_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  bus_req_t req,
	output byte_t    rdata
);

	// 64 sprites of 4 bytes
	byte_t oam [256];

	byte_t oam_addr;

	logic wr_addr;
	logic wr_data;
	logic rd_addr;
	logic rd_data;

	// Register strobes
	assign wr_addr = req.we && (req.addr == ADDR_OAMADDR);
	assign wr_data = req.we && (req.addr == ADDR_OAMDATA);
	assign rd_addr = req.re && (req.addr == ADDR_OAMADDR);
	assign rd_data = req.re && (req.addr == ADDR_OAMDATA);

	// OAMADDR pointer
	// Data writes step it, the byte wraps from $FF to $00 by itself
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			oam_addr <= '0;
		end else if (wr_addr) begin
			oam_addr <= req.wdata;
		end else if (wr_data) begin
			oam_addr <= oam_addr + 8'd1;
		end
	end

	// Sprite memory
	always_ff @(posedge clk) begin
		if (wr_data) begin
			oam[oam_addr] <= req.wdata;
		end
	end

	// Registered read, pointer is left alone on reads
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			rdata <= '0;
		end else if (rd_addr) begin
			// Readback of OAMADDR, needed to save it across a DMA
			rdata <= oam_addr;
		end else if (rd_data) begin
			rdata <= oam[oam_addr];
		end
	end

	// Both masters keep the strobes apart
	a_no_rw_overlap: assert property (@(posedge clk) disable iff (!rst)
		!(req.we && req.re));

endmodule

// ==== hdl/nes_oam_dma_top.sv ====
`timescale 1ns/100ps

module nes_oam_dma_top
	import nes_bus_pkg::*;
	import oam_dma_pkg::*;
#(
	parameter int RAM_ADDR_W = 11
)
(
	input  logic     clk,
	input  logic     rst,
	input  bus_req_t cpu_req,
	output byte_t    cpu_rdata,
	output logic     busy
);

	// Engine control
	dma_ctrl_t ctrl;
	logic      count_clear;
	logic      count_advance;
	logic      last_byte;
	byte_t     count;
	logic      dma_start;
	byte_t     dma_page;

	// Bus side
	bus_req_t  dma_req;
	bus_req_t  ram_req;
	bus_req_t  oam_req;
	byte_t     ram_rdata;
	byte_t     oam_rdata;
	byte_t     bus_rdata;

	// CPU sees the same return data as the engine
	assign cpu_rdata = bus_rdata;

	oam_dma_fsm u_fsm (
		.clk           (clk),
		.rst           (rst),
		.dma_start     (dma_start),
		.last_byte     (last_byte),
		.busy          (busy),
		.ctrl          (ctrl),
		.count_clear   (count_clear),
		.count_advance (count_advance)
	);

	dma_byte_counter u_counter (
		.clk       (clk),
		.rst       (rst),
		.clear     (count_clear),
		.advance   (count_advance),
		.count     (count),
		.last_byte (last_byte)
	);

	dma_address_path u_addr_path (
		.clk       (clk),
		.rst       (rst),
		.dma_start (dma_start),
		.dma_page  (dma_page),
		.ctrl      (ctrl),
		.count     (count),
		.bus_rdata (bus_rdata),
		.dma_req   (dma_req)
	);

	bus_master_mux u_mux (
		.clk       (clk),
		.rst       (rst),
		.busy      (busy),
		.cpu_req   (cpu_req),
		.dma_req   (dma_req),
		.ram_req   (ram_req),
		.oam_req   (oam_req),
		.ram_rdata (ram_rdata),
		.oam_rdata (oam_rdata),
		.bus_rdata (bus_rdata),
		.dma_start (dma_start),
		.dma_page  (dma_page)
	);

	cpu_work_ram #(
		.RAM_ADDR_W (RAM_ADDR_W)
	) u_ram (
		.clk   (clk),
		.rst   (rst),
		.req   (ram_req),
		.rdata (ram_rdata)
	);

	ppu_oam_regs u_oam (
		.clk   (clk),
		.rst   (rst),
		.req   (oam_req),
		.rdata (oam_rdata)
	);

endmodule

// ==== verif/tb_nes_oam_dma.sv ====
`timescale 1ns/100ps

module tb_nes_oam_dma
	import nes_bus_pkg::*;
();

	localparam int CLK_PERIOD   = 10;
	localparam int RESET_CYCLES = 5;
	localparam int PAGE_BYTES   = 256;
	// SAVE, CLEAR, 256 READ/WRITE pairs, RESTORE
	localparam int DMA_CYCLES   = 515;
	// Whole run is near 2600 cycles: two fills, two DMAs, two readbacks
	localparam int TIMEOUT_CYCLES = 5000;
	localparam int unsigned RAND_SEED = 32'hebb9cc58;

	logic     clk;
	logic     rst;
	bus_req_t cpu_req;
	byte_t    cpu_rdata;
	logic     busy;

	// Reference copy of source page $03
	byte_t page [PAGE_BYTES];
	int    busy_len;
	int    error_count;
	logic  start_req;

	nes_oam_dma_top #(
		.RAM_ADDR_W (11)
	) dut (
		.clk       (clk),
		.rst       (rst),
		.cpu_req   (cpu_req),
		.cpu_rdata (cpu_rdata),
		.busy      (busy)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	// Idle bus plus a CPU write to $4014 must start a transfer
	assign start_req = cpu_req.we && (cpu_req.addr == ADDR_OAMDMA) && !busy;

	// Length of the current busy window
	always @(posedge clk or negedge rst) begin
		if (!rst) begin
			busy_len <= 0;
		end else if (busy) begin
			busy_len <= busy_len + 1;
		end else begin
			busy_len <= 0;
		end
	end

	task automatic abort_run();
		$display("Simulation FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic report_error(input string what);
		error_count = error_count + 1;
		$display("FAIL at %0t: %s", $time, what);
		abort_run();
	endtask

	// Busy follows the trigger by exactly one edge
	a_busy_rise: assert property (@(posedge clk) disable iff (!rst)
		start_req |=> $rose(busy))
		else report_error("busy did not rise on the edge after the $4014 write");

	// No transfer without a trigger, so a write during busy cannot restart it
	a_busy_cause: assert property (@(posedge clk) disable iff (!rst)
		$rose(busy) |-> $past(start_req))
		else report_error("busy rose without a $4014 write on an idle bus");

	a_busy_len: assert property (@(posedge clk) disable iff (!rst)
		$fell(busy) |-> ($sampled(busy_len) == DMA_CYCLES))
		else report_error($sformatf("busy was high for %0d cycles, expected %0d",
			$sampled(busy_len), DMA_CYCLES));

	a_busy_max: assert property (@(posedge clk) disable iff (!rst)
		busy_len <= DMA_CYCLES)
		else report_error($sformatf("busy stayed high past %0d cycles", DMA_CYCLES));

	// Inputs change 1 ns after the rising edge
	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic cpu_write(input addr_t addr, input byte_t data);
		cpu_req.addr  = addr;
		cpu_req.wdata = data;
		cpu_req.we    = 1'b1;
		step();
		cpu_req.we = 1'b0;
	endtask

	// Data is due one cycle after the read strobe
	task automatic cpu_read(input addr_t addr, output byte_t data);
		cpu_req.addr = addr;
		cpu_req.re   = 1'b1;
		step();
		cpu_req.re = 1'b0;
		data = cpu_rdata;
	endtask

	task automatic check_read(input addr_t addr, input byte_t expected, input string what);
		byte_t got;
		cpu_read(addr, got);
		a_read_value: assert (got === expected)
		else report_error($sformatf("%s, read of %04h expected %02h got %02h",
			what, addr, expected, got));
	endtask

	task automatic wait_dma_done();
		// Watchdog covers a busy that never falls
		while (busy) begin
			step();
		end
		step();
	endtask

	task automatic check_ram_mirror();
		a_idle_after_reset: assert (busy === 1'b0)
		else report_error("busy is not low after reset");
		cpu_write(16'h0005, 8'h5A);
		check_read(16'h0005, 8'h5A, "work RAM readback");
		// 2 KB RAM repeats every $0800
		check_read(16'h0805, 8'h5A, "work RAM mirror");
	endtask

	task automatic check_oam_registers();
		cpu_write(ADDR_OAMADDR, 8'h10);
		cpu_write(ADDR_OAMDATA, 8'hC1);
		cpu_write(ADDR_OAMDATA, 8'hC2);
		cpu_write(ADDR_OAMDATA, 8'hC3);
		// Three data writes step OAMADDR from $10
		check_read(ADDR_OAMADDR, 8'h13, "OAMADDR after three data writes");
		cpu_write(ADDR_OAMADDR, 8'h11);
		check_read(ADDR_OAMDATA, 8'hC2, "OAMDATA at $11");
	endtask

	task automatic load_source_page();
		for (int k = 0; k < PAGE_BYTES; k++) begin
			cpu_write(addr_t'(16'h0300 + k), page[k]);
		end
	endtask

	// Sets every OAM byte to the inverse of the page
	task automatic overwrite_oam();
		cpu_write(ADDR_OAMADDR, 8'h00);
		for (int k = 0; k < PAGE_BYTES; k++) begin
			cpu_write(ADDR_OAMDATA, ~page[k]);
		end
	endtask

	task automatic check_oam_contents();
		for (int k = 0; k < PAGE_BYTES; k++) begin
			cpu_write(ADDR_OAMADDR, byte_t'(k));
			check_read(ADDR_OAMDATA, page[k], $sformatf("OAM byte %0d", k));
		end
	endtask

	task automatic check_first_dma();
		load_source_page();
		cpu_write(ADDR_OAMADDR, 8'h40);
		cpu_write(ADDR_OAMDMA, 8'h03);
		wait_dma_done();
		check_read(ADDR_OAMADDR, 8'h40, "OAMADDR restored after DMA");
		check_oam_contents();
	endtask

	task automatic check_dma_with_cpu_traffic();
		overwrite_oam();
		cpu_write(ADDR_OAMADDR, 8'h20);
		cpu_write(ADDR_OAMDMA, 8'h03);
		repeat (10) step();
		// Both writes land while the engine owns the bus
		cpu_write(16'h0300, 8'hAA);
		step();
		cpu_write(ADDR_OAMDMA, 8'h05);
		wait_dma_done();
		repeat (4) step();
		a_no_restart: assert (busy === 1'b0)
		else report_error("a second transfer started after the DMA ended");
		check_read(ADDR_OAMADDR, 8'h20, "OAMADDR restored after second DMA");
		check_read(16'h0300, page[0], "work RAM written during DMA");
		check_oam_contents();
	endtask

	initial begin
		cpu_req     = '0;
		rst         = 1'b0;
		error_count = 0;
		void'($urandom(RAND_SEED));
		for (int k = 0; k < PAGE_BYTES; k++) begin
			page[k] = byte_t'($urandom);
		end
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst = 1'b1;
		step();
		check_ram_mirror();
		check_oam_registers();
		check_first_dma();
		check_dma_with_cpu_traffic();
		repeat (2) step();
		if (error_count == 0) begin
			$display("Simulation PASSED");
			$finish;
		end else begin
			abort_run();
		end
	end

	// Watchdog
	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
		abort_run();
	end

endmodule

// ==== nes_oam_dma.f ====
hdl/nes_bus_pkg.sv
hdl/oam_dma_pkg.sv
hdl/oam_dma_fsm.sv
hdl/dma_byte_counter.sv
hdl/dma_address_path.sv
hdl/bus_master_mux.sv
hdl/cpu_work_ram.sv
hdl/ppu_oam_regs.sv
hdl/nes_oam_dma_top.sv
verif/tb_nes_oam_dma.sv

// ==== Makefile ====
# Verilator build of the sprite DMA testbench
# Any variable can be set on the command line, e.g. make run TOP=...

VERILATOR ?= verilator
TOP       ?= tb_nes_oam_dma
FILELIST  ?= nes_oam_dma.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
PASS_TEXT ?= Simulation PASSED

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Result is taken from the simulator output, no log file is kept
run: compile
	@out="$$($(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
